// File: bench/clock_gen.sv
/*
 * testbench clock and reset
 * 4 ns clock, reset held for 2 cycles and on request
 */
`timescale 1ns/1ns

module clock_gen (
  input  logic reset_req,
  output logic clk,
  output logic rst_n
);
  logic por_n;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    por_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    por_n <= 1'b1;  // released on a falling edge
  end

  assign rst_n = por_n && !reset_req;

endmodule

// File: bench/echo_canceller_tb.sv
/*
 * echo canceller testbench
 * directed tests against a bit-exact LMS reference model
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module echo_canceller_tb;
  import aec_audio_pkg::*;

  localparam int WAIT_LIMIT = 2000;  // cycles per wait loop
  localparam int FILL_MAX   = `AEC_FIFO_DEPTH - 1;

  logic         clk;
  logic         rst_n;
  logic         reset_req;
  logic         in_valid;
  sample_pair_t in_pair;
  logic         full;
  logic         lms_on;
  logic         out_read;
  sample_t      out_sample;
  logic         out_empty;
  level_t       out_level;
  logic [31:0]  seed;
  sample_t      m_taps [`AEC_TAPS];  // model delay line with 0 newest
  longint       m_w [`AEC_TAPS];     // model weights, Q14

  clock_gen u_clock_gen (.reset_req(reset_req), .clk(clk), .rst_n(rst_n));

  echo_canceller_top u_echo_canceller_top (
    .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_pair(in_pair), .full(full),
    .lms_on(lms_on), .out_read(out_read), .out_sample(out_sample),
    .out_empty(out_empty), .out_level(out_level)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic compare_level(input string name, input level_t got, input level_t exp);
    if (got !== exp) stop_run($sformatf("FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic sample_t small_sample();
    logic [31:0] r;
    r = lcg_next();
    return sample_t'($signed(r[31:16]) >>> 7);  // about +-256 keeps LMS stable
  endfunction

  function automatic sample_pair_t random_pair();
    sample_pair_t p;
    logic [31:0]  r;
    p.far = small_sample();
    r     = lcg_next();
    p.mic = sample_t'(r[23:8]);
    return p;
  endfunction

  // half-level echo of the far sample three steps back
  function automatic sample_pair_t echo_pair();
    sample_pair_t p;
    p.far = small_sample();
    p.mic = sample_t'(m_taps[2] >>> 1);
    return p;
  endfunction

  function automatic void model_reset();
    for (int j = 0; j < `AEC_TAPS; j++) begin
      m_taps[j] = '0;
      m_w[j]    = 0;
    end
  endfunction

  // shift, dot product, saturated error, then optional LMS update
  function automatic sample_t model_step(input sample_pair_t p, input logic adapt);
    longint sum;
    longint e;
    longint w_new;
    for (int j = `AEC_TAPS - 1; j > 0; j--) m_taps[j] = m_taps[j-1];
    m_taps[0] = p.far;
    sum = 0;
    for (int j = 0; j < `AEC_TAPS; j++) sum += m_w[j] * longint'(m_taps[j]);
    e = longint'(p.mic) - (sum >>> `AEC_COEF_FRAC);
    if (e > 32767) e = 32767;
    else if (e < -32768) e = -32768;
    if (adapt) begin
      for (int j = 0; j < `AEC_TAPS; j++) begin
        w_new = m_w[j] + ((e * longint'(m_taps[j])) >>> `AEC_MU_SHIFT);
        if (w_new > 131071) w_new = 131071;
        else if (w_new < -131072) w_new = -131072;
        m_w[j] = w_new;
      end
    end
    return sample_t'(e);
  endfunction

  task automatic write_pair(input sample_pair_t p);
    int n;
    n = 0;
    while (full) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run("input FIFO stayed full too long");
    end
    in_pair  = p;
    in_valid = 1'b1;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic read_output(output sample_t s);
    int n;
    n = 0;
    while (out_empty) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run("no output sample arrived in time");
    end
    s        = out_sample;
    out_read = 1'b1;
    @(negedge clk);
    out_read = 1'b0;
  endtask

  // every error equals its mic sample with zero weights
  task automatic pass_through(input int count);
    sample_pair_t p;
    sample_t      got;
    lms_on = 1'b0;
    for (int i = 0; i < count; i++) begin
      p = random_pair();
      void'(model_step(p, 1'b0));  // model delay line follows the DUT
      write_pair(p);
      read_output(got);
      compare_sample("out_sample", got, p.mic);
    end
  endtask

  task automatic adaptive_cancel();
    sample_pair_t p;
    sample_t      got;
    int           first_sum;
    int           last_sum;
    lms_on    = 1'b1;
    first_sum = 0;
    last_sum  = 0;
    for (int i = 0; i < 200; i++) begin
      p = echo_pair();
      write_pair(p);
      read_output(got);
      compare_sample("out_sample", got, model_step(p, 1'b1));
      if (i < 20) first_sum += (got < 0) ? -int'(got) : int'(got);
      if (i >= 180) last_sum += (got < 0) ? -int'(got) : int'(got);
    end
    if (last_sum >= first_sum) begin
      stop_run($sformatf("error did not shrink: first %0d, last %0d", first_sum, last_sum));
    end
  endtask

  // uncorrelated mic gives large errors that would move any live weight
  task automatic frozen_weights(input int count);
    sample_pair_t p;
    sample_t      got;
    lms_on = 1'b0;
    for (int i = 0; i < count; i++) begin
      p = random_pair();
      write_pair(p);
      read_output(got);
      compare_sample("out_sample", got, model_step(p, 1'b0));
    end
  endtask

  task automatic back_pressure();
    sample_t      exp_q [$];
    sample_pair_t p;
    sample_t      got;
    logic         saw_full;
    int           n;
    lms_on   = 1'b1;
    saw_full = 1'b0;
    for (int i = 0; i < 2 * `AEC_FIFO_DEPTH + 8; i++) begin
      p = echo_pair();
      if (full) saw_full = 1'b1;  // this strobe gets dropped
      else exp_q.push_back(model_step(p, 1'b1));
      in_pair  = p;
      in_valid = 1'b1;
      @(negedge clk);
    end
    in_valid = 1'b0;
    if (!saw_full) stop_run("full never rose with the reader stalled");
    n = 0;
    while (out_level != level_t'(FILL_MAX)) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run("output level never reached its limit");
    end
    repeat (40) @(negedge clk);
    compare_level("out_level", out_level, level_t'(FILL_MAX));
    while (exp_q.size() > 0) begin
      read_output(got);
      compare_sample("out_sample", got, exp_q.pop_front());
    end
    repeat (30) @(negedge clk);
    if (!out_empty) stop_run("more output samples than accepted inputs");
  endtask

  task automatic mid_stream_reset();
    lms_on = 1'b1;
    for (int i = 0; i < 6; i++) begin
      in_pair  = echo_pair();
      in_valid = 1'b1;
      @(negedge clk);
    end
    in_valid = 1'b0;
    repeat (5) @(negedge clk);  // a sample is in flight here
    reset_req = 1'b1;
    repeat (2) @(negedge clk);
    reset_req = 1'b0;
    @(negedge clk);
    if (!out_empty) stop_run("out_empty not high right after reset");
    compare_level("out_level", out_level, '0);
    model_reset();
    pass_through(20);
  endtask

  initial begin
    int n;
    seed      = 32'h10ab_4522;
    in_valid  = 1'b0;
    in_pair   = '0;
    lms_on    = 1'b0;
    out_read  = 1'b0;
    reset_req = 1'b0;
    model_reset();
    n = 0;
    @(negedge clk);
    while (!rst_n) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) stop_run("reset never released");
    end
    pass_through(20);
    adaptive_cancel();
    frozen_weights(40);
    back_pressure();
    mid_stream_reset();
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: include/aec_defines.svh
/*
 * echo canceller build constants
 * filter length, lane split, LMS step and FIFO sizing
 */
`ifndef AEC_DEFINES_SVH
`define AEC_DEFINES_SVH

`define AEC_TAPS        16  // filter length
`define AEC_LANES       4   // parallel tap lanes, divides AEC_TAPS

// LMS step size as a power of two
`define AEC_MU_SHIFT    6

`define AEC_COEF_FRAC   14  // weight fraction bits
`define AEC_FIFO_DEPTH  16  // entries per FIFO

`endif

// File: list.f
+incdir+include
src/aec_audio_pkg.sv
src/aec_filter_pkg.sv
src/sample_fifo.sv
src/lms_sequencer.sv
src/tap_shifter.sv
src/tap_lane.sv
src/error_combiner.sv
src/echo_canceller_top.sv
bench/clock_gen.sv
bench/echo_canceller_tb.sv

// File: run.sh
#!/bin/sh
# build and run the echo canceller testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module echo_canceller_tb --Mdir obj_dir -o echo_canceller_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/echo_canceller_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation clean"
exit 0

// File: src/aec_audio_pkg.sv
/*
 * audio stream types
 * samples, far/mic pairs and FIFO fill counts
 */
package aec_audio_pkg;

  // 16-bit two's complement PCM
  typedef logic signed [15:0] sample_t;

  // one input word: far-end reference plus microphone
  typedef struct packed {
    sample_t far;  // loudspeaker reference
    sample_t mic;  // microphone with echo and near-end speech
  } sample_pair_t;

  // fill count, must hold 0..depth
  typedef logic [4:0] level_t;

endpackage

// File: src/aec_filter_pkg.sv
/*
 * LMS filter types
 * weight and accumulator formats, per-lane control word
 */
`include "aec_defines.svh"

package aec_filter_pkg;

  typedef logic signed [17:0] weight_t;  // Q3.14
  typedef logic signed [39:0] acc_t;     // 16 x 18 products, 16 taps, headroom

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_DOT,    // multiply-accumulate
    PH_UPDATE  // weight adaptation
  } lane_phase_t;

  typedef struct packed {
    lane_phase_t phase;
    logic [1:0]  idx;    // tap within a lane
    logic        first;  // restart accumulator
    logic        adapt;  // update enabled for this sample
  } lane_ctrl_t;

  // one entry per lane
  typedef aec_audio_pkg::sample_t [`AEC_LANES-1:0] lane_x_t;
  typedef acc_t [`AEC_LANES-1:0] lane_acc_t;

endpackage

// File: src/echo_canceller_top.sv
/*
 * acoustic echo canceller top
 * input FIFO, LMS sequencer, tap delay line, tap lanes, error combiner, output FIFO
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module echo_canceller_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  aec_audio_pkg::sample_pair_t in_pair,
  output logic                       full,
  input  logic                       lms_on,
  input  logic                       out_read,
  output aec_audio_pkg::sample_t     out_sample,
  output logic                       out_empty,
  output aec_audio_pkg::level_t      out_level
);
  import aec_audio_pkg::*;
  import aec_filter_pkg::*;

  sample_pair_t in_head;
  logic         in_empty;
  logic         seq_pop;
  logic         seq_shift;
  logic         seq_combine;
  lane_ctrl_t   lane_ctrl;
  lane_x_t      lane_x;
  lane_acc_t    lane_acc;
  sample_t      err;
  logic         err_push;

  sample_fifo #(.WIDTH($bits(sample_pair_t)), .DEPTH(`AEC_FIFO_DEPTH)) u_in_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(in_valid), .wdata(in_pair),
    .pop(seq_pop), .rdata(in_head),
    .empty(in_empty), .full(full), .level()
  );

  lms_sequencer u_lms_sequencer (
    .clk(clk), .rst_n(rst_n),
    .in_empty(in_empty), .out_level(out_level), .lms_on(lms_on),
    .pop(seq_pop), .shift(seq_shift), .lane_ctrl(lane_ctrl), .combine(seq_combine)
  );

  tap_shifter u_tap_shifter (
    .clk(clk), .rst_n(rst_n),
    .shift(seq_shift), .far(in_head.far), .lane_ctrl(lane_ctrl), .lane_x(lane_x)
  );

  for (genvar g = 0; g < `AEC_LANES; g++) begin : g_lane
    tap_lane u_tap_lane (
      .clk(clk), .rst_n(rst_n),
      .lane_ctrl(lane_ctrl), .x(lane_x[g]), .err(err), .acc(lane_acc[g])
    );
  end

  error_combiner u_error_combiner (
    .clk(clk), .rst_n(rst_n),
    .pop(seq_pop), .mic(in_head.mic), .combine(seq_combine),
    .lane_acc(lane_acc), .err(err), .push(err_push)
  );

  // never full since the sequencer keeps one slot free
  sample_fifo #(.WIDTH($bits(sample_t)), .DEPTH(`AEC_FIFO_DEPTH)) u_out_fifo (
    .clk(clk), .rst_n(rst_n),
    .push(err_push), .wdata(err),
    .pop(out_read), .rdata(out_sample),
    .empty(out_empty), .full(), .level(out_level)
  );

endmodule

// File: src/error_combiner.sv
/*
 * error combiner
 * sums the lane partials into the echo estimate, err = mic - y saturated
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module error_combiner (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      pop,
  input  aec_audio_pkg::sample_t    mic,
  input  logic                      combine,
  input  aec_filter_pkg::lane_acc_t lane_acc,
  output aec_audio_pkg::sample_t    err,
  output logic                      push
);
  import aec_audio_pkg::*;
  import aec_filter_pkg::*;

  localparam acc_t ERR_MAX = 40'sd32767;
  localparam acc_t ERR_MIN = -40'sd32768;

  sample_t mic_q;
  sample_t err_q;
  sample_t err_next;
  logic    push_q;
  acc_t    sum;
  acc_t    y;     // estimate in sample units
  acc_t    diff;

  always_comb begin
    sum = '0;
    for (int l = 0; l < `AEC_LANES; l++) begin
      sum = sum + acc_t'(lane_acc[l]);
    end
  end

  assign y    = sum >>> `AEC_COEF_FRAC;  // drop weight fraction
  assign diff = acc_t'(mic_q) - y;

  always_comb begin
    if (diff > ERR_MAX) begin
      err_next = 16'sh7fff;
    end else if (diff < ERR_MIN) begin
      err_next = 16'sh8000;
    end else begin
      err_next = diff[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      mic_q <= mic;  // mic arrives with the far sample
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q  <= '0;
      push_q <= 1'b0;
    end else begin
      push_q <= combine;
      if (combine) begin
        err_q <= err_next;  // held through the update phase
      end
    end
  end

  assign err  = err_q;
  assign push = push_q;

endmodule

// File: src/lms_sequencer.sv
/*
 * per-sample sequencer
 * pop, dot product, error combine and optional weight update
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module lms_sequencer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_empty,
  input  aec_audio_pkg::level_t      out_level,
  input  logic                       lms_on,
  output logic                       pop,
  output logic                       shift,
  output aec_filter_pkg::lane_ctrl_t lane_ctrl,
  output logic                       combine
);
  import aec_audio_pkg::*;
  import aec_filter_pkg::*;

  localparam logic [1:0] LAST_IDX = 2'(`AEC_TAPS / `AEC_LANES - 1);

  typedef enum logic [2:0] {S_WAIT, S_POP, S_DOT, S_COMB, S_UPD} seq_state_t;

  seq_state_t state_q;
  logic [1:0] cnt_q;    // tap index and combine cycle count
  logic       adapt_q;
  logic       start;

  // leave room for the one sample in flight
  assign start = !in_empty && (out_level < level_t'(`AEC_FIFO_DEPTH - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_WAIT;
      cnt_q   <= '0;
      adapt_q <= 1'b0;
    end else begin
      case (state_q)
        S_WAIT: begin
          if (start) begin
            state_q <= S_POP;
          end
        end
        S_POP: begin
          adapt_q <= lms_on;  // held for the whole sample
          cnt_q   <= '0;
          state_q <= S_DOT;
        end
        S_DOT: begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == LAST_IDX) begin
            cnt_q   <= '0;
            state_q <= S_COMB;
          end
        end
        S_COMB: begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == 2'd1) begin  // err is ready now
            cnt_q   <= '0;
            state_q <= adapt_q ? S_UPD : S_WAIT;
          end
        end
        S_UPD: begin
          cnt_q <= cnt_q + 2'd1;
          if (cnt_q == LAST_IDX) begin
            cnt_q   <= '0;
            state_q <= S_WAIT;
          end
        end
        default: state_q <= S_WAIT;
      endcase
    end
  end

  always_comb begin
    pop             = (state_q == S_POP);
    combine         = (state_q == S_COMB) && (cnt_q == 2'd0);
    lane_ctrl.idx   = cnt_q;
    lane_ctrl.first = (state_q == S_DOT) && (cnt_q == 2'd0);
    lane_ctrl.adapt = adapt_q;
    case (state_q)
      S_DOT:   lane_ctrl.phase = PH_DOT;
      S_UPD:   lane_ctrl.phase = PH_UPDATE;
      default: lane_ctrl.phase = PH_IDLE;
    endcase
  end

  assign shift = pop;  // far sample enters the delay line with the pop

  a_pop_has_data: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !in_empty);

endmodule

// File: src/sample_fifo.sv
/*
 * synchronous FIFO, first word fall through
 * head word always on rdata, fill level reported
 */
`timescale 1ns/1ns

module sample_fifo #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  logic [WIDTH-1:0]      wdata,
  input  logic                  pop,
  output logic [WIDTH-1:0]      rdata,
  output logic                  empty,
  output logic                  full,
  output aec_audio_pkg::level_t level
);
  import aec_audio_pkg::*;

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  level_t           count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;  // strobe while full is dropped
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count_q <= count_q + level_t'(do_push) - level_t'(do_pop);
    end
  end

  assign rdata = mem[rd_ptr];
  assign empty = (count_q == '0);
  assign full  = (count_q == level_t'(DEPTH));
  assign level = count_q;

  // the head word holds until it is popped
  a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!empty && !pop) |=> $stable(rdata));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

// File: src/tap_lane.sv
/*
 * one LMS tap lane
 * owns a slice of weights, MACs in the dot phase, adapts in the update phase
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module tap_lane (
  input  logic                       clk,
  input  logic                       rst_n,
  input  aec_filter_pkg::lane_ctrl_t lane_ctrl,
  input  aec_audio_pkg::sample_t     x,
  input  aec_audio_pkg::sample_t     err,
  output aec_filter_pkg::acc_t       acc
);
  import aec_filter_pkg::*;

  localparam int LANE_TAPS = `AEC_TAPS / `AEC_LANES;

  // weight_t limits in the update adder width
  localparam logic signed [32:0] W_MAX = 33'sd131071;
  localparam logic signed [32:0] W_MIN = -33'sd131072;

  weight_t            w_q [LANE_TAPS];
  acc_t               acc_q;
  acc_t               acc_base;
  weight_t            w_cur;
  weight_t            w_sat;
  logic signed [33:0] mac_prod;  // w * x
  logic signed [31:0] upd_prod;  // err * x
  logic signed [32:0] w_sum;

  assign w_cur    = w_q[lane_ctrl.idx];
  assign mac_prod = w_cur * x;
  assign upd_prod = err * x;
  assign w_sum    = w_cur + (upd_prod >>> `AEC_MU_SHIFT);
  assign acc_base = lane_ctrl.first ? acc_t'(0) : acc_q;

  always_comb begin
    if (w_sum > W_MAX) begin
      w_sat = weight_t'(W_MAX);
    end else if (w_sum < W_MIN) begin
      w_sat = weight_t'(W_MIN);
    end else begin
      w_sat = w_sum[17:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      for (int i = 0; i < LANE_TAPS; i++) begin
        w_q[i] <= '0;
      end
    end else begin
      if (lane_ctrl.phase == PH_DOT) begin
        acc_q <= acc_base + acc_t'(mac_prod);
      end
      if (lane_ctrl.phase == PH_UPDATE && lane_ctrl.adapt) begin
        w_q[lane_ctrl.idx] <= w_sat;
      end
    end
  end

  assign acc = acc_q;

  a_idx_in_lane: assert property (@(posedge clk) disable iff (!rst_n)
    (lane_ctrl.phase != PH_IDLE) |-> (int'(lane_ctrl.idx) < LANE_TAPS));
  // the sequencer only enters update for a sample popped with lms_on high
  a_update_adapt: assert property (@(posedge clk) disable iff (!rst_n)
    (lane_ctrl.phase == PH_UPDATE) |-> lane_ctrl.adapt);

endmodule

// File: src/tap_shifter.sv
/*
 * far-end tap delay line
 * shifts in one sample per pop, serves each lane its current tap
 */
`timescale 1ns/1ns
`include "aec_defines.svh"

module tap_shifter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       shift,
  input  aec_audio_pkg::sample_t     far,
  input  aec_filter_pkg::lane_ctrl_t lane_ctrl,
  output aec_filter_pkg::lane_x_t    lane_x
);
  import aec_audio_pkg::*;

  localparam int LANE_TAPS = `AEC_TAPS / `AEC_LANES;

  sample_t taps_q [`AEC_TAPS];  // taps_q[0] is the newest sample

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `AEC_TAPS; i++) begin
        taps_q[i] <= '0;
      end
    end else if (shift) begin
      taps_q[0] <= far;
      for (int i = 1; i < `AEC_TAPS; i++) begin
        taps_q[i] <= taps_q[i-1];
      end
    end
  end

  // lane l owns taps l*LANE_TAPS .. l*LANE_TAPS+LANE_TAPS-1
  always_comb begin
    for (int l = 0; l < `AEC_LANES; l++) begin
      if (lane_ctrl.phase == aec_filter_pkg::PH_IDLE) begin
        lane_x[l] = '0;  // keeps the multipliers quiet
      end else begin
        lane_x[l] = taps_q[l*LANE_TAPS + int'(lane_ctrl.idx)];
      end
    end
  end

endmodule
